/* Makefile */
# Verilator build and run of the execute engine testbench

VERILATOR ?= verilator
TOP       ?= tb_MipsExecCore
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/ExecuteUnit.sv */
// Processing part of the execute engine
//  - Operand read from the register file
//  - Immediate or register B as second operand
//  - ALU result and write back on the acceptance edge
`timescale 1ns/10ps

module ExecuteUnit import MipsPkg::*; (
    input  logic        i_Clock,
    input  logic        i_rst,

    // Decoded op stream
    input  logic        i_OpValid,
    input  DecodedOp_t  i_Op,
    output logic        o_OpReady,

    // Result stream
    output logic        o_ResValid,
    output ExecResult_t o_Res,
    input  logic        i_ResReady
);

    logic [DataWidth-1:0] RdDataA, RdDataB;
    logic [DataWidth-1:0] OperandB;
    logic [DataWidth-1:0] AluValue;
    logic                 Accept;    // Result taken at this edge
    logic                 WrEnable;

    // ------------------------------------------------------------
    // Handshake, passed straight through
    // ------------------------------------------------------------
    assign o_ResValid = i_OpValid;
    assign o_OpReady  = i_ResReady;
    assign Accept     = i_OpValid && i_ResReady;
    assign WrEnable   = Accept && !i_Op.Illegal && (i_Op.DestReg != '0);

    RegisterFile RegisterFile_i (
        .i_Clock    (i_Clock),
        .i_rst      (i_rst),
        .i_WrAddr   (i_Op.DestReg),
        .i_WrData   (o_Res.Value),
        .i_WrEnable (WrEnable),
        .i_RdAddrA  (i_Op.SrcA),
        .o_RdDataA  (RdDataA),
        .i_RdAddrB  (i_Op.SrcB),
        .o_RdDataB  (RdDataB)
    );

    assign OperandB = i_Op.UseImm ? i_Op.Imm : RdDataB;

    IntegerAlu IntegerAlu_i (
        .i_AluOp    (i_Op.AluOp),
        .i_OperandA (RdDataA),
        .i_OperandB (OperandB),
        .o_Value    (AluValue)
    );

    // Result record, illegal ops carry zero
    always_comb begin
        o_Res.DestReg = i_Op.DestReg;
        o_Res.Value   = i_Op.Illegal ? '0 : AluValue;
        o_Res.Illegal = i_Op.Illegal;
    end

endmodule

/* design/InstrDecoder.sv */
// Input side of the execute engine
//  - Field split of the instruction word
//  - ALU op, destination and immediate extension
//  - Registered through a one-entry stage
`timescale 1ns/10ps

module InstrDecoder import MipsPkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rst,

    // Instruction stream
    input  logic                  i_InstrValid,
    input  logic [InstrWidth-1:0] i_Instr,
    output logic                  o_InstrReady,

    // Decoded op stream
    output logic                  o_OpValid,
    output DecodedOp_t            o_Op,
    input  logic                  i_OpReady
);

    logic [OpcodeWidth-1:0]  Opcode;
    logic [FunctWidth-1:0]   Funct;
    logic [RegAddrWidth-1:0] Rs, Rt, Rd;
    logic [ImmWidth-1:0]     Imm;
    logic [DataWidth-1:0]    ImmSigned, ImmZero;
    DecodedOp_t              Decoded;

    assign Opcode = i_Instr[31:26];
    assign Rs     = i_Instr[25:21];
    assign Rt     = i_Instr[20:16];
    assign Rd     = i_Instr[15:11];
    assign Funct  = i_Instr[FunctWidth-1:0];
    assign Imm    = i_Instr[ImmWidth-1:0];

    assign ImmSigned = {{(DataWidth-ImmWidth){Imm[ImmWidth-1]}}, Imm};
    assign ImmZero   = {{(DataWidth-ImmWidth){1'b0}}, Imm};

    always_comb begin
        Decoded       = '0;
        Decoded.AluOp = AluAdd;
        Decoded.SrcA  = Rs;
        Decoded.SrcB  = Rt;
        case (Opcode)
            OpSpecial: begin
                Decoded.DestReg = Rd;  // R-type writes rd
                case (Funct)
                    FnAddu:  Decoded.AluOp = AluAdd;
                    FnSubu:  Decoded.AluOp = AluSub;
                    FnAnd:   Decoded.AluOp = AluAnd;
                    FnOr:    Decoded.AluOp = AluOr;
                    FnXor:   Decoded.AluOp = AluXor;
                    FnNor:   Decoded.AluOp = AluNor;
                    FnSlt:   Decoded.AluOp = AluSlt;
                    FnSltu:  Decoded.AluOp = AluSltu;
                    default: Decoded.Illegal = 1'b1;
                endcase
            end
            // Arithmetic immediates are sign extended
            OpAddiu: {Decoded.AluOp, Decoded.Imm} = {AluAdd, ImmSigned};
            OpSlti:  {Decoded.AluOp, Decoded.Imm} = {AluSlt, ImmSigned};
            // Logic immediates and LUI are zero extended
            OpAndi:  {Decoded.AluOp, Decoded.Imm} = {AluAnd, ImmZero};
            OpOri:   {Decoded.AluOp, Decoded.Imm} = {AluOr, ImmZero};
            OpXori:  {Decoded.AluOp, Decoded.Imm} = {AluXor, ImmZero};
            OpLui:   {Decoded.AluOp, Decoded.Imm} = {AluLui, ImmZero};
            default: Decoded.Illegal = 1'b1;
        endcase

        if (Opcode != OpSpecial) begin
            Decoded.UseImm  = 1'b1;
            Decoded.DestReg = Rt;  // I-type writes rt
        end
        if (Decoded.Illegal)
            Decoded.DestReg = '0;  // Never targets a register
    end

    PipeStage #(.Payload_t(DecodedOp_t)) OpStage_i (
        .i_Clock (i_Clock),
        .i_rst   (i_rst),
        .i_Valid (i_InstrValid),
        .i_Data  (Decoded),
        .o_Ready (o_InstrReady),
        .o_Valid (o_OpValid),
        .o_Data  (o_Op),
        .i_Ready (i_OpReady)
    );

endmodule

/* design/IntegerAlu.sv */
// Combinational integer ALU
//  - Wraparound add and subtract
//  - Bitwise logic, signed and unsigned set-less-than, LUI
`timescale 1ns/10ps

module IntegerAlu import MipsPkg::*; (
    input  AluOp_t               i_AluOp,
    input  logic [DataWidth-1:0] i_OperandA,
    input  logic [DataWidth-1:0] i_OperandB,
    output logic [DataWidth-1:0] o_Value
);

    logic LessSigned, LessUnsigned;

    assign LessSigned   = $signed(i_OperandA) < $signed(i_OperandB);
    assign LessUnsigned = i_OperandA < i_OperandB;

    always_comb begin
        case (i_AluOp)
            AluAdd:  o_Value = i_OperandA + i_OperandB;  // Carry dropped
            AluSub:  o_Value = i_OperandA - i_OperandB;
            AluAnd:  o_Value = i_OperandA & i_OperandB;
            AluOr:   o_Value = i_OperandA | i_OperandB;
            AluXor:  o_Value = i_OperandA ^ i_OperandB;
            AluNor:  o_Value = ~(i_OperandA | i_OperandB);
            AluSlt:  o_Value = DataWidth'(LessSigned);
            AluSltu: o_Value = DataWidth'(LessUnsigned);
            // Immediate moved to the upper half, rs ignored
            AluLui:  o_Value = {i_OperandB[ImmWidth-1:0], {(DataWidth-ImmWidth){1'b0}}};
            default: o_Value = '0;
        endcase
    end

endmodule

/* design/MipsExecCore.sv */
// Top level of the integer execute engine
//  - Decoder stage, execute unit, output result stage
//  - Two items in flight, one per cycle throughput
`timescale 1ns/10ps

module MipsExecCore import MipsPkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rst,

    // Instruction stream in
    input  logic                  i_InstrValid,
    input  logic [InstrWidth-1:0] i_Instr,
    output logic                  o_InstrReady,

    // Result stream out
    output logic                  o_ResultValid,
    output ExecResult_t           o_Result,
    input  logic                  i_ResultReady
);

    // Decoder to execute unit
    logic        OpValid, OpReady;
    DecodedOp_t  Op;
    // Execute unit to output stage
    logic        ResValid, ResReady;
    ExecResult_t Res;

    InstrDecoder InstrDecoder_i (
        .i_Clock      (i_Clock),
        .i_rst        (i_rst),
        .i_InstrValid (i_InstrValid),
        .i_Instr      (i_Instr),
        .o_InstrReady (o_InstrReady),
        .o_OpValid    (OpValid),
        .o_Op         (Op),
        .i_OpReady    (OpReady)
    );

    ExecuteUnit ExecuteUnit_i (
        .i_Clock    (i_Clock),
        .i_rst      (i_rst),
        .i_OpValid  (OpValid),
        .i_Op       (Op),
        .o_OpReady  (OpReady),
        .o_ResValid (ResValid),
        .o_Res      (Res),
        .i_ResReady (ResReady)
    );

    PipeStage #(.Payload_t(ExecResult_t)) ResultStage_i (
        .i_Clock (i_Clock),
        .i_rst   (i_rst),
        .i_Valid (ResValid),
        .i_Data  (Res),
        .o_Ready (ResReady),
        .o_Valid (o_ResultValid),
        .o_Data  (o_Result),
        .i_Ready (i_ResultReady)
    );

endmodule

/* design/MipsPkg.sv */
// Shared definitions of the integer execute engine
//  - Data, register index and field widths
//  - Opcode and function codes of the supported instructions
//  - ALU operation enum
//  - Decoded op and result records
package MipsPkg;

    localparam int DataWidth    = 32;  // Register and result width
    localparam int RegAddrWidth = 5;   // 32 registers
    localparam int InstrWidth   = 32;
    localparam int OpcodeWidth  = 6;
    localparam int FunctWidth   = 6;
    localparam int ImmWidth     = 16;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    localparam logic [OpcodeWidth-1:0] OpSpecial = 6'h00;  // R-type group
    localparam logic [OpcodeWidth-1:0] OpAddiu   = 6'h09;
    localparam logic [OpcodeWidth-1:0] OpSlti    = 6'h0A;
    localparam logic [OpcodeWidth-1:0] OpAndi    = 6'h0C;
    localparam logic [OpcodeWidth-1:0] OpOri     = 6'h0D;
    localparam logic [OpcodeWidth-1:0] OpXori    = 6'h0E;
    localparam logic [OpcodeWidth-1:0] OpLui     = 6'h0F;

    localparam logic [FunctWidth-1:0] FnAddu = 6'h21;
    localparam logic [FunctWidth-1:0] FnSubu = 6'h23;
    localparam logic [FunctWidth-1:0] FnAnd  = 6'h24;
    localparam logic [FunctWidth-1:0] FnOr   = 6'h25;
    localparam logic [FunctWidth-1:0] FnXor  = 6'h26;
    localparam logic [FunctWidth-1:0] FnNor  = 6'h27;
    localparam logic [FunctWidth-1:0] FnSlt  = 6'h2A;
    localparam logic [FunctWidth-1:0] FnSltu = 6'h2B;

    // ------------------------------------------------------------
    // Records
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor, AluSlt, AluSltu, AluLui
    } AluOp_t;

    typedef struct packed {
        AluOp_t                  AluOp;
        logic [RegAddrWidth-1:0] SrcA;     // rs
        logic [RegAddrWidth-1:0] SrcB;     // rt, R-type only
        logic [RegAddrWidth-1:0] DestReg;  // Zero when illegal
        logic [DataWidth-1:0]    Imm;      // Already extended
        logic                    UseImm;
        logic                    Illegal;
    } DecodedOp_t;

    typedef struct packed {
        logic [RegAddrWidth-1:0] DestReg;
        logic [DataWidth-1:0]    Value;
        logic                    Illegal;
    } ExecResult_t;

endpackage

/* design/PipeStage.sv */
// One-entry valid/ready register stage
//  - Payload type chosen per instance
//  - Ready flows back combinationally, no skid buffer
`timescale 1ns/10ps

module PipeStage #(
    parameter type Payload_t = logic [31:0]  // Record held by the stage
) (
    input  logic     i_Clock,
    input  logic     i_rst,

    // Upstream side
    input  logic     i_Valid,
    input  Payload_t i_Data,
    output logic     o_Ready,

    // Downstream side
    output logic     o_Valid,
    output Payload_t o_Data,
    input  logic     i_Ready
);

    logic     Full;   // Entry occupied
    Payload_t Data;

    // Free now, or emptied at this edge
    assign o_Ready = !Full || i_Ready;

    always_ff @(posedge i_Clock) begin
        if (i_rst)
            Full <= 1'b0;
        else if (o_Ready)
            Full <= i_Valid;  // Refill or drain
    end

    always_ff @(posedge i_Clock) begin
        if (i_Valid && o_Ready)
            Data <= i_Data;
    end

    assign o_Valid = Full;
    assign o_Data  = Data;

endmodule

/* design/RegisterFile.sv */
// MIPS register file
//  - One write port for registers 1 to 31
//  - Two independent combinational read ports
//  - Register 0 always reads zero
`timescale 1ns/10ps

module RegisterFile import MipsPkg::*; (
    input  logic                    i_Clock,
    input  logic                    i_rst,

    // Write port
    input  logic [RegAddrWidth-1:0] i_WrAddr,
    input  logic [DataWidth-1:0]    i_WrData,
    input  logic                    i_WrEnable,

    // Read port A
    input  logic [RegAddrWidth-1:0] i_RdAddrA,
    output logic [DataWidth-1:0]    o_RdDataA,

    // Read port B
    input  logic [RegAddrWidth-1:0] i_RdAddrB,
    output logic [DataWidth-1:0]    o_RdDataB
);

    localparam int NumRegs = 2 ** RegAddrWidth;

    // No storage behind register 0
    logic [DataWidth-1:0] Regs [1:NumRegs-1];

    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 1; i < NumRegs; i++)
                Regs[i] <= '0;
        end
        else if (i_WrEnable && (i_WrAddr != '0)) begin
            Regs[i_WrAddr] <= i_WrData;
        end
    end

    // Index 0 and reset read as zero
    always_comb begin
        o_RdDataA = (i_rst || (i_RdAddrA == '0)) ? '0 : Regs[i_RdAddrA];
        o_RdDataB = (i_rst || (i_RdAddrB == '0)) ? '0 : Regs[i_RdAddrB];
    end

endmodule

/* src.f */
design/MipsPkg.sv
design/PipeStage.sv
design/InstrDecoder.sv
design/RegisterFile.sv
design/IntegerAlu.sv
design/ExecuteUnit.sv
design/MipsExecCore.sv
tests/MipsExecCore_properties.sv
tests/ExecChecker.sv
tests/tb_MipsExecCore.sv

/* tests/ExecChecker.sv */
// Scoreboard of the execute engine
//  - Register model with register 0 fixed at zero
//  - Expected results queued at the input handshake
//  - Compare against the queue head at the output handshake
`timescale 1ns/10ps

module ExecChecker import MipsPkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rst,
    input  logic                  i_InstrValid,
    input  logic [InstrWidth-1:0] i_Instr,
    input  logic                  i_InstrReady,
    input  logic                  i_ResultValid,
    input  ExecResult_t           i_Result,
    input  logic                  i_ResultReady,
    output int                    o_InstrCount,
    output int                    o_ResultCount,
    output int                    o_ErrorCount
);

    logic [DataWidth-1:0] Model [32];  // Architectural registers
    ExecResult_t          Expected [$];

    // Result of one word, from the MIPS rules and the model state
    function automatic ExecResult_t Predict(input logic [InstrWidth-1:0] Word);
        ExecResult_t          Res;
        logic [DataWidth-1:0] A, B, SExt, ZExt;
        A    = Model[Word[25:21]];  // rs
        B    = Model[Word[20:16]];  // rt
        SExt = {{16{Word[15]}}, Word[15:0]};
        ZExt = {16'h0000, Word[15:0]};
        Res  = '0;
        Res.DestReg = Word[20:16];  // rt for immediates
        case (Word[31:26])
            OpSpecial: begin
                Res.DestReg = Word[15:11];
                case (Word[5:0])
                    FnAddu:  Res.Value = A + B;
                    FnSubu:  Res.Value = A - B;
                    FnAnd:   Res.Value = A & B;
                    FnOr:    Res.Value = A | B;
                    FnXor:   Res.Value = A ^ B;
                    FnNor:   Res.Value = ~(A | B);
                    FnSlt:   Res.Value = {31'b0, $signed(A) < $signed(B)};
                    FnSltu:  Res.Value = {31'b0, A < B};
                    default: Res.Illegal = 1'b1;
                endcase
            end
            OpAddiu: Res.Value = A + SExt;  // Wraps at 32 bits
            OpSlti:  Res.Value = {31'b0, $signed(A) < $signed(SExt)};
            OpAndi:  Res.Value = A & ZExt;
            OpOri:   Res.Value = A | ZExt;
            OpXori:  Res.Value = A ^ ZExt;
            OpLui:   Res.Value = {Word[15:0], 16'h0000};
            default: Res.Illegal = 1'b1;
        endcase
        if (Res.Illegal) begin
            Res.DestReg = '0;
            Res.Value   = '0;
        end
        return Res;
    endfunction

    // ----------------------------------------------------------
    // Handshake monitor
    // ----------------------------------------------------------
    always @(posedge i_Clock) begin
        ExecResult_t Exp;
        if (i_rst) begin
            for (int i = 0; i < 32; i++)
                Model[i] = '0;
            Expected.delete();
            o_InstrCount  = 0;
            o_ResultCount = 0;
            o_ErrorCount  = 0;
        end
        else begin
            if (i_InstrValid && i_InstrReady) begin
                Exp = Predict(i_Instr);
                if (!Exp.Illegal && (Exp.DestReg != '0))
                    Model[Exp.DestReg] = Exp.Value;  // Register 0 never stored
                Expected.push_back(Exp);
                o_InstrCount++;
            end
            if (i_ResultValid && i_ResultReady) begin
                o_ResultCount++;
                if (Expected.size() == 0) begin
                    $display("Error at %0t: result delivered with no instruction outstanding",
                             $time);
                    o_ErrorCount++;
                end
                else begin
                    Exp = Expected.pop_front();
                    if (i_Result !== Exp) begin
                        $display("FAILED at %0t: o_Result expected r%0d=%h ill=%b, actual r%0d=%h ill=%b",
                                 $time, Exp.DestReg, Exp.Value, Exp.Illegal,
                                 i_Result.DestReg, i_Result.Value, i_Result.Illegal);
                        o_ErrorCount++;
                    end
                end
            end
        end
    end

endmodule

/* tests/MipsExecCore_properties.sv */
// Concurrent checks on the execute engine handshakes
//  - No result in the cycle after reset
//  - Result record steady under back-pressure
//  - Result valid kept until taken
//  - Input ready low only while the output stalls
`timescale 1ns/10ps

module MipsExecCore_properties import MipsPkg::*; (
    input logic        i_Clock,
    input logic        i_rst,
    input logic        i_InstrReady,
    input logic        i_ResultValid,
    input ExecResult_t i_Result,
    input logic        i_ResultReady
);

    int AssertFailures = 0;  // Failed assertion count

    ResetClearsValid: assert property (@(posedge i_Clock) $past(i_rst) |-> !i_ResultValid)
        else begin
            $error("o_ResultValid high in the cycle after reset");
            AssertFailures++;
        end

    // Output stage holds its item while stalled
    ResultStable: assert property (@(posedge i_Clock) disable iff (i_rst)
        (i_ResultValid && !i_ResultReady) |=> $stable(i_Result))
        else begin
            $error("o_Result changed while waiting for i_ResultReady");
            AssertFailures++;
        end

    ResultHeld: assert property (@(posedge i_Clock) disable iff (i_rst)
        (i_ResultValid && !i_ResultReady) |=> i_ResultValid)
        else begin
            $error("o_ResultValid dropped before the result was taken");
            AssertFailures++;
        end

    // Both stages full and the consumer waiting
    InstrReadyStall: assert property (@(posedge i_Clock) disable iff (i_rst)
        !i_InstrReady |-> (i_ResultValid && !i_ResultReady))
        else begin
            $error("o_InstrReady low while the output stage could drain");
            AssertFailures++;
        end

endmodule

/* tests/tb_MipsExecCore.sv */
// Testbench top of the integer execute engine
//  - Clock, reset and seeded random instruction stream
//  - Random result back-pressure
//  - Checker and bound assertions
//  - One line per test and a closing report
`timescale 1ns/10ps

module tb_MipsExecCore import MipsPkg::*; ();

    localparam int WaitLimit = 200;  // Cycles before any wait gives up

    logic                  i_Clock;
    logic                  i_rst;
    logic                  i_InstrValid;
    logic [InstrWidth-1:0] i_Instr;
    logic                  o_InstrReady;
    logic                  o_ResultValid;
    ExecResult_t           o_Result;
    logic                  i_ResultReady;

    int InstrCount, ResultCount, ErrorCount;  // From the checker
    int LocalErrors  = 0;
    int PrevErrors   = 0;
    int TestsFailed  = 0;
    bit BackPressure = 1'b0;  // Random stalls on the result side

    MipsExecCore MipsExecCore_i (.*);

    bind MipsExecCore MipsExecCore_properties Props_i (
        .i_Clock       (i_Clock),
        .i_rst         (i_rst),
        .i_InstrReady  (o_InstrReady),
        .i_ResultValid (o_ResultValid),
        .i_Result      (o_Result),
        .i_ResultReady (i_ResultReady)
    );

    ExecChecker Checker_i (
        .i_Clock       (i_Clock),
        .i_rst         (i_rst),
        .i_InstrValid  (i_InstrValid),
        .i_Instr       (i_Instr),
        .i_InstrReady  (o_InstrReady),
        .i_ResultValid (o_ResultValid),
        .i_Result      (o_Result),
        .i_ResultReady (i_ResultReady),
        .o_InstrCount  (InstrCount),
        .o_ResultCount (ResultCount),
        .o_ErrorCount  (ErrorCount)
    );

    initial begin
        i_Clock = 1'b0;
        forever #50 i_Clock = ~i_Clock;
    end

    // Consumer drops ready about a third of the time under back-pressure
    initial begin
        i_ResultReady = 1'b1;
        forever begin
            @(posedge i_Clock);
            #1;
            i_ResultReady = !BackPressure || (($urandom % 3) != 0);
        end
    end

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    function automatic logic [InstrWidth-1:0] RandomInstr(input int IllegalPercent,
                                                          input logic [4:0] RegMask);
        logic [RegAddrWidth-1:0] Rs, Rt, Rd;
        logic [ImmWidth-1:0]     Imm;
        logic [FunctWidth-1:0]   Functs [8];
        logic [OpcodeWidth-1:0]  Opcodes [8];
        int                      Pick;
        Functs  = '{FnAddu, FnSubu, FnAnd, FnOr, FnXor, FnNor, FnSlt, FnSltu};
        Opcodes = '{OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui, OpAddiu, OpSlti};
        Rs   = RegAddrWidth'($urandom) & RegMask;
        Rt   = RegAddrWidth'($urandom) & RegMask;
        Rd   = RegAddrWidth'($urandom) & RegMask;
        Imm  = ImmWidth'($urandom);
        Pick = int'($urandom % 100);
        if (Pick < IllegalPercent)  // LW or MULT lie outside the subset
            return Pick[0] ? {6'h23, Rs, Rt, Imm} : {OpSpecial, Rs, Rt, Rd, 5'd0, 6'h18};
        if (Pick[0])
            return {OpSpecial, Rs, Rt, Rd, 5'd0, Functs[3'($urandom)]};
        return {Opcodes[3'($urandom)], Rs, Rt, Imm};
    endfunction

    function automatic int TotalErrors();
        return ErrorCount + LocalErrors + MipsExecCore_i.Props_i.AssertFailures;
    endfunction

    task automatic Abort(input string What);
        $display("Timeout at %0t: %s", $time, What);
        $display("Test failed");
        $finish;
    endtask

    // Hold valid until taken and sample ready mid-cycle
    task automatic SendInstr(input logic [InstrWidth-1:0] Word, input bit AllowGap);
        int Cycles;
        bit Taken;
        Cycles = 0;
        Taken  = 1'b0;
        if (AllowGap && (($urandom % 4) == 0)) begin
            repeat (1 + $urandom % 3) begin
                @(posedge i_Clock);
                #1;
            end
        end
        i_InstrValid = 1'b1;
        i_Instr      = Word;
        while (!Taken) begin
            if (Cycles == WaitLimit)
                Abort("instruction never accepted by the core");
            @(negedge i_Clock);
            Taken = o_InstrReady;
            @(posedge i_Clock);
            #1;
            Cycles++;
        end
        i_InstrValid = 1'b0;
    endtask

    task automatic FinishTest(input int Num, input string Name);
        int Cycles;
        int Errors;
        Cycles = 0;
        while (ResultCount != InstrCount) begin  // Drain both stages
            if (Cycles == WaitLimit)
                Abort("results still outstanding after the drain wait");
            @(posedge i_Clock);
            #1;
            Cycles++;
        end
        Errors     = TotalErrors() - PrevErrors;
        PrevErrors = TotalErrors();
        if (Errors != 0)
            TestsFailed++;
        $display("Test %0d %s: %0d errors, %0d results so far", Num, Name, Errors, ResultCount);
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        void'($urandom(49));
        i_rst        = 1'b1;
        i_InstrValid = 1'b0;
        i_Instr      = '0;
        repeat (5) @(posedge i_Clock);
        #1;
        i_rst = 1'b0;

        // Empty pipeline and then r5 = r0 + r0
        @(negedge i_Clock);
        if (o_ResultValid !== 1'b0) begin
            $display("FAILED at %0t: o_ResultValid expected 0, actual %b", $time, o_ResultValid);
            LocalErrors++;
        end
        if (o_InstrReady !== 1'b1) begin
            $display("FAILED at %0t: o_InstrReady expected 1, actual %b", $time, o_InstrReady);
            LocalErrors++;
        end
        @(posedge i_Clock);
        #1;
        SendInstr({OpSpecial, 5'd0, 5'd0, 5'd5, 5'd0, FnAddu}, 1'b0);
        FinishTest(1, "after reset");

        repeat (300) SendInstr(RandomInstr(0, 5'h1F), 1'b1);
        FinishTest(2, "supported operations");

        // Writes to r0 report a value but r0 still reads zero
        SendInstr({OpOri, 5'd0, 5'd0, 16'h1234}, 1'b0);
        SendInstr({OpSpecial, 5'd0, 5'd0, 5'd6, 5'd0, FnAddu}, 1'b0);
        SendInstr({OpAddiu, 5'd0, 5'd7, 16'hFFFF}, 1'b0);
        SendInstr({OpSpecial, 5'd7, 5'd0, 5'd0, 5'd0, FnNor}, 1'b0);
        SendInstr({OpSpecial, 5'd0, 5'd7, 5'd8, 5'd0, FnSltu}, 1'b0);
        FinishTest(3, "register zero");

        BackPressure = 1'b1;
        repeat (60) SendInstr(RandomInstr(50, 5'h1F), 1'b1);
        FinishTest(4, "illegal words");

        // Only four registers so most ops depend on the previous one
        repeat (150) SendInstr(RandomInstr(10, 5'h03), 1'b0);
        FinishTest(5, "back-to-back dependency");

        $display("Summary: %0d tests failed, %0d instructions, %0d results, %0d errors",
                 TestsFailed, InstrCount, ResultCount, TotalErrors());
        if ((TestsFailed == 0) && (TotalErrors() == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
